//--- Makefile
TOP := opcode_deco_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- project.f
+incdir+test
src/isa_pkg.sv
src/micro_pkg.sv
src/opcode_capture.sv
src/ea_decode.sv
src/instr_decode.sv
src/deco_issue.sv
src/opcode_deco.sv
test/opcode_deco_tb.sv

//--- src/deco_issue.sv
// Output stage. Merges the opcode class record with the effective-address
// decode and registers the finished record with its strobe.

module deco_issue
        import isa_pkg::*;
        import micro_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      cap_valid,
        input  deco_t     cls,
        input  reg_code_t ea_base,
        input  reg_code_t ea_index,
        input  reg_code_t ea_seg,
        input  logic      ea_disp,
        input  logic      ea_disp16,
        output logic      deco_valid,
        output deco_t     deco
);

        deco_t rec;

        always_comb
        begin
                rec = cls;
                if (cls.need_modrm)
                begin
                        rec.base     = ea_base;
                        rec.index    = ea_index;
                        rec.seg      = ea_seg;
                        rec.need_off = ea_disp;
                        rec.off_size = ea_disp16;
                end
                else
                begin
                        rec.base     = REG_NONE;
                        rec.index    = REG_NONE;
                        rec.seg      = SEG_DS;
                        rec.need_off = 1'b0;
                        rec.off_size = 1'b0;
                end
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        deco_valid <= 1'b0;
                        deco       <= '0;
                end
                else
                begin
                        deco_valid <= cap_valid;
                        if (cap_valid)
                                deco <= rec;  // held until the next item
                end
        end

        // a 16-bit size only ever comes with a displacement
        a_off_size_needs_off: assert property (@(posedge clk) disable iff (!rst_n)
                deco_valid |-> (!deco.off_size || deco.need_off))
                else $error("off_size without need_off");

endmodule

//--- src/ea_decode.sv
// Effective-address table of the 8086 ModR/M byte.
// Gives base, index and default segment of the memory operand and whether
// a displacement follows, and of what size.

module ea_decode
        import isa_pkg::*;
(
        input  op_fields_t cap,
        output reg_code_t  ea_base,
        output reg_code_t  ea_index,
        output reg_code_t  ea_seg,
        output logic       ea_disp,
        output logic       ea_disp16
);

        logic [1:0] mod;
        logic [2:0] rm;
        logic       direct;

        assign mod    = cap.modrm.opnd.mod;
        assign rm     = cap.modrm.opnd.rm;
        assign direct = (mod == 2'd0) && (rm == RM_DIRECT);

        always_comb
        begin
                {ea_base, ea_index} = {REG_NONE, REG_NONE};
                case (rm)
                        3'd0: {ea_base, ea_index} = {REG_BX, REG_SI};
                        3'd1: {ea_base, ea_index} = {REG_BX, REG_DI};
                        3'd2: {ea_base, ea_index} = {REG_BP, REG_SI};
                        3'd3: {ea_base, ea_index} = {REG_BP, REG_DI};
                        3'd4: {ea_base, ea_index} = {REG_SI, REG_NONE};
                        3'd5: {ea_base, ea_index} = {REG_DI, REG_NONE};
                        3'd6: {ea_base, ea_index} = {REG_BP, REG_NONE};
                        3'd7: {ea_base, ea_index} = {REG_BX, REG_NONE};
                        default: ;
                endcase
                if (direct)
                        {ea_base, ea_index} = {REG_NONE, REG_NONE};  // [disp16]
        end

        // bp-based addressing defaults to the stack segment
        assign ea_seg    = (ea_base == REG_BP) ? SEG_SS : SEG_DS;
        assign ea_disp   = direct || (mod == 2'd1) || (mod == 2'd2);
        assign ea_disp16 = direct || (mod == 2'd2);

endmodule

//--- src/instr_decode.sv
// Opcode class decode. Maps the captured opcode and ModR/M fields to a
// microcode start address, operand registers and immediate need.
// The effective-address fields of the record are left zero here and
// filled in by the issue stage.

module instr_decode
        import isa_pkg::*;
        import micro_pkg::*;
(
        input  op_fields_t cap,
        output deco_t      cls
);

        logic       byte_op;
        logic       d_bit;
        logic       reg_form;
        logic [2:0] reg_f;
        logic [2:0] rm_f;
        logic       imm_word;
        alu_kind_e  kind;
        seq_addr_t  blk;
        reg_code_t  opnd_src;
        reg_code_t  opnd_dst;
        reg_code_t  short_reg;

        function automatic seq_addr_t form_addr(seq_addr_t base, logic [2:0] form,
                                                logic word);
                return base + seq_addr_t'({form, word});
        endfunction

        assign byte_op  = ~cap.op[0];
        assign d_bit    = cap.op[1];
        assign reg_form = (cap.modrm.opnd.mod == MOD_REG);
        assign reg_f    = cap.modrm.opnd.reg_fld;
        assign rm_f     = cap.modrm.opnd.rm;
        assign imm_word = cap.op[0] & ~cap.op[1];  // 83 sign-extends a byte

        // group 1 takes the family from ModR/M
        assign kind = cap.op[7] ? alu_kind_e'(cap.modrm.grp.ext_op)
                                : alu_kind_e'(cap.op[5:3]);

        always_comb
        begin
                case (kind)
                        ALU_ADD: blk = SEQ_ADD;
                        ALU_ADC: blk = SEQ_ADC;
                        ALU_SBB: blk = SEQ_SBB;
                        ALU_SUB: blk = SEQ_SUB;
                        ALU_CMP: blk = SEQ_CMP;
                        ALU_OR, ALU_AND, ALU_XOR: blk = SEQ_LOG;
                        default: blk = SEQ_LOG;
                endcase
        end

        // d set: reg field is the destination
        assign opnd_src  = d_bit ? {1'b0, rm_f} : {1'b0, reg_f};
        assign opnd_dst  = d_bit ? {1'b0, reg_f} : {1'b0, rm_f};
        assign short_reg = {1'b0, cap.op[2:0]};

        always_comb
        begin
                cls          = '0;
                cls.seq_addr = SEQ_HLT;
                casez (cap.op)
                        8'b00??_?0??: // alu r/m forms
                        begin
                                if (reg_form)
                                        cls.seq_addr = form_addr(blk, FORM_RR, !byte_op);
                                else if (d_bit)
                                        cls.seq_addr = form_addr(blk, FORM_MR, !byte_op);
                                else
                                        cls.seq_addr = form_addr(blk, FORM_RM, !byte_op);
                                cls.need_modrm = 1'b1;
                                cls.src        = opnd_src;
                                cls.dst        = opnd_dst;
                        end
                        8'b00??_?10?: // alu accumulator, immediate
                        begin
                                cls.seq_addr = form_addr(blk, FORM_IR, !byte_op);
                                cls.need_imm = 1'b1;
                                cls.imm_size = imm_word;
                        end
                        8'b1000_00??: // group 1
                        begin
                                cls.seq_addr   = form_addr(blk, reg_form ? FORM_IR : FORM_IM,
                                                           !byte_op);
                                cls.need_modrm = 1'b1;
                                cls.need_imm   = 1'b1;
                                cls.imm_size   = imm_word;
                                cls.dst        = {1'b0, rm_f};
                        end
                        8'b1000_10??: // mov
                        begin
                                cls.need_modrm = 1'b1;
                                cls.src        = opnd_src;
                                cls.dst        = opnd_dst;
                                if (reg_form)
                                begin
                                        cls.seq_addr = form_addr(SEQ_MOV, FORM_RR, !byte_op);
                                end
                                else if (d_bit)
                                begin
                                        cls.seq_addr = form_addr(SEQ_MOV, FORM_MR, !byte_op);
                                        cls.src      = '0;  // memory source
                                end
                                else
                                begin
                                        cls.seq_addr = form_addr(SEQ_MOV, FORM_RM, !byte_op);
                                        cls.dst      = '0;  // memory destination
                                end
                        end
                        8'b0100_0???:
                        begin
                                cls.seq_addr = SEQ_INCRW;
                                cls.src      = short_reg;
                        end
                        8'b0100_1???:
                        begin
                                cls.seq_addr = SEQ_DECRW;
                                cls.src      = short_reg;
                        end
                        8'b0101_0???:
                        begin
                                cls.seq_addr = SEQ_PUSHR;
                                cls.src      = short_reg;
                        end
                        8'b0101_1???:
                        begin
                                cls.seq_addr = SEQ_POPR;
                                cls.dst      = short_reg;
                        end
                        8'b1011_????: // mov imm to reg, op[3] is word
                        begin
                                cls.seq_addr = SEQ_MOVIR + seq_addr_t'(cap.op[3]);
                                cls.need_imm = 1'b1;
                                cls.imm_size = cap.op[3];
                                cls.dst      = short_reg;
                        end
                        default: ;  // halt
                endcase
        end

endmodule

//--- src/isa_pkg.sv
// 8086 instruction-set encodings shared by the decoder stages.
// Holds the opcode and ModR/M field layouts and the register codes that
// appear in the decoded record.

package isa_pkg;

        // 0-7 general registers, 8-11 segment registers
        typedef logic [3:0] reg_code_t;

        localparam reg_code_t REG_AX   = 4'd0;
        localparam reg_code_t REG_CX   = 4'd1;
        localparam reg_code_t REG_DX   = 4'd2;
        localparam reg_code_t REG_BX   = 4'd3;
        localparam reg_code_t REG_SP   = 4'd4;
        localparam reg_code_t REG_BP   = 4'd5;
        localparam reg_code_t REG_SI   = 4'd6;
        localparam reg_code_t REG_DI   = 4'd7;
        localparam reg_code_t SEG_ES   = 4'd8;
        localparam reg_code_t SEG_CS   = 4'd9;
        localparam reg_code_t SEG_SS   = 4'd10;
        localparam reg_code_t SEG_DS   = 4'd11;
        localparam reg_code_t REG_NONE = 4'd12;  // no register in this slot

        localparam logic [1:0] MOD_REG   = 2'd3;  // rm names a register
        localparam logic [2:0] RM_DIRECT = 3'd6;  // with mod 0 only

        // two-operand ALU families, in opcode bit 5:3 order
        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_OR,
                ALU_ADC,
                ALU_SBB,
                ALU_AND,
                ALU_SUB,
                ALU_XOR,
                ALU_CMP
        } alu_kind_e;

        // ModR/M as register and r/m operands
        typedef struct packed {
                logic [1:0] mod;
                logic [2:0] reg_fld;
                logic [2:0] rm;
        } modrm_opnd_t;

        // ModR/M of 80-83, middle field picks the operation
        typedef struct packed {
                logic [1:0] mod;
                logic [2:0] ext_op;
                logic [2:0] rm;
        } modrm_grp_t;

        typedef union packed {
                modrm_opnd_t opnd;
                modrm_grp_t  grp;
        } modrm_u;

        typedef struct packed {
                logic [7:0] op;
                modrm_u     modrm;
        } op_fields_t;

endpackage

//--- src/micro_pkg.sv
// Microcode ROM layout and the decoded record handed to the sequencer.
// ALU families own 16-entry blocks indexed by form and word bit; the
// short register forms and halt have single entries after them.

package micro_pkg;

        localparam int SEQ_AW = 9;

        typedef logic [SEQ_AW-1:0] seq_addr_t;

        // block bases, offset inside a block is form * 2 + word
        localparam seq_addr_t SEQ_ADD = 9'd0;
        localparam seq_addr_t SEQ_ADC = 9'd16;
        localparam seq_addr_t SEQ_SBB = 9'd32;
        localparam seq_addr_t SEQ_SUB = 9'd48;
        localparam seq_addr_t SEQ_CMP = 9'd64;
        localparam seq_addr_t SEQ_LOG = 9'd80;   // or, and, xor
        localparam seq_addr_t SEQ_MOV = 9'd96;

        localparam logic [2:0] FORM_RR = 3'd0;
        localparam logic [2:0] FORM_RM = 3'd1;  // reg to mem
        localparam logic [2:0] FORM_MR = 3'd2;  // mem to reg
        localparam logic [2:0] FORM_IR = 3'd3;
        localparam logic [2:0] FORM_IM = 3'd4;

        // single entries
        localparam seq_addr_t SEQ_INCRW = 9'd112;
        localparam seq_addr_t SEQ_DECRW = 9'd113;
        localparam seq_addr_t SEQ_PUSHR = 9'd114;
        localparam seq_addr_t SEQ_POPR  = 9'd115;
        localparam seq_addr_t SEQ_MOVIR = 9'd116;  // +1 for word
        localparam seq_addr_t SEQ_HLT   = 9'd120;

        typedef struct packed {
                seq_addr_t          seq_addr;
                logic               need_modrm;
                logic               need_off;
                logic               off_size;   // 1 = 16-bit displacement
                logic               need_imm;
                logic               imm_size;   // 1 = 16-bit immediate
                isa_pkg::reg_code_t src;
                isa_pkg::reg_code_t dst;
                isa_pkg::reg_code_t base;
                isa_pkg::reg_code_t index;
                isa_pkg::reg_code_t seg;
        } deco_t;

endpackage

//--- src/opcode_capture.sv
// Input stage of the decoder. Registers the opcode and ModR/M bytes on
// op_valid and presents them as one field record one cycle later.

module opcode_capture
        import isa_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       op_valid,
        input  logic [7:0] op,
        input  logic [7:0] modrm,
        output logic       cap_valid,
        output op_fields_t cap
);

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        cap_valid <= 1'b0;
                else
                        cap_valid <= op_valid;  // one-cycle pulse per strobe
        end

        always_ff @(posedge clk)
        begin
                if (op_valid)
                begin
                        cap.op    <= op;
                        cap.modrm <= modrm_u'(modrm);
                end
        end

        a_strobe_known: assert property (@(posedge clk) disable iff (!rst_n)
                op_valid |-> !$isunknown({op, modrm}))
                else $error("opcode bytes unknown under op_valid");

endmodule

//--- src/opcode_deco.sv
// Registered 8086 opcode decoder. An opcode/ModR/M pair strobed on
// op_valid comes back as one decoded record on deco_valid two edges later.
// No back-pressure; a new pair may be strobed every cycle.

module opcode_deco
        import isa_pkg::*;
        import micro_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       op_valid,
        input  logic [7:0] op,
        input  logic [7:0] modrm,
        output logic       deco_valid,
        output deco_t      deco
);

        logic       cap_valid;
        op_fields_t cap;
        reg_code_t  ea_base;
        reg_code_t  ea_index;
        reg_code_t  ea_seg;
        logic       ea_disp;
        logic       ea_disp16;
        deco_t      cls;

        opcode_capture opcode_capture_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .op_valid  (op_valid),
                .op        (op),
                .modrm     (modrm),
                .cap_valid (cap_valid),
                .cap       (cap)
        );

        ea_decode ea_decode_i (
                .cap       (cap),
                .ea_base   (ea_base),
                .ea_index  (ea_index),
                .ea_seg    (ea_seg),
                .ea_disp   (ea_disp),
                .ea_disp16 (ea_disp16)
        );

        instr_decode instr_decode_i (
                .cap (cap),
                .cls (cls)
        );

        deco_issue deco_issue_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .cap_valid  (cap_valid),
                .cls        (cls),
                .ea_base    (ea_base),
                .ea_index   (ea_index),
                .ea_seg     (ea_seg),
                .ea_disp    (ea_disp),
                .ea_disp16  (ea_disp16),
                .deco_valid (deco_valid),
                .deco       (deco)
        );

endmodule

//--- test/deco_expect.svh
// Reference model of the opcode decoder, built from the instruction rules.
// Included inside the testbench module, which imports isa_pkg and micro_pkg.
`ifndef DECO_EXPECT_SVH
`define DECO_EXPECT_SVH

function automatic seq_addr_t family_base(input logic [2:0] fam);
        case (fam)
                3'd0: return SEQ_ADD;
                3'd2: return SEQ_ADC;
                3'd3: return SEQ_SBB;
                3'd5: return SEQ_SUB;
                3'd7: return SEQ_CMP;
                default: return SEQ_LOG;  // or, and, xor
        endcase
endfunction

function automatic deco_t expected_record(input logic [7:0] op_b, input logic [7:0] modrm_b);
        deco_t      r;
        logic [1:0] md;
        logic [2:0] rg;
        logic [2:0] rm;
        logic       w;
        logic       mem;
        logic       direct;
        int         form;
        r          = '0;
        r.seq_addr = SEQ_HLT;
        md         = modrm_b[7:6];
        rg         = modrm_b[5:3];
        rm         = modrm_b[2:0];
        w          = op_b[0];
        mem        = (md != 2'd3);
        direct     = (md == 2'd0) && (rm == 3'd6);
        form       = !mem ? 0 : (op_b[1] ? 2 : 1);
        if (op_b < 8'h40 && op_b[2] == 1'b0)
        begin
                r.seq_addr   = family_base(op_b[5:3]) + seq_addr_t'(form * 2 + w);
                r.need_modrm = 1'b1;
                r.src        = op_b[1] ? {1'b0, rm} : {1'b0, rg};
                r.dst        = op_b[1] ? {1'b0, rg} : {1'b0, rm};
        end
        else if (op_b < 8'h40 && op_b[2:1] == 2'b10)
        begin
                r.seq_addr = family_base(op_b[5:3]) + seq_addr_t'(6 + w);
                r.need_imm = 1'b1;
                r.imm_size = w;
        end
        else if (op_b >= 8'h80 && op_b <= 8'h83)
        begin
                r.seq_addr   = family_base(rg) + seq_addr_t'((mem ? 8 : 6) + w);
                r.need_modrm = 1'b1;
                r.need_imm   = 1'b1;
                r.imm_size   = w & ~op_b[1];  // 83 carries a byte
                r.dst        = {1'b0, rm};
        end
        else if (op_b >= 8'h88 && op_b <= 8'h8B)
        begin
                r.seq_addr   = SEQ_MOV + seq_addr_t'(form * 2 + w);
                r.need_modrm = 1'b1;
                r.src        = (mem && op_b[1]) ? 4'd0 : (op_b[1] ? {1'b0, rm} : {1'b0, rg});
                r.dst        = (mem && !op_b[1]) ? 4'd0 : (op_b[1] ? {1'b0, rg} : {1'b0, rm});
        end
        else if (op_b >= 8'h40 && op_b <= 8'h5F)
        begin
                case (op_b[4:3])
                        2'd0: r.seq_addr = SEQ_INCRW;
                        2'd1: r.seq_addr = SEQ_DECRW;
                        2'd2: r.seq_addr = SEQ_PUSHR;
                        default: r.seq_addr = SEQ_POPR;
                endcase
                if (op_b[4:3] == 2'd3)
                        r.dst = {1'b0, op_b[2:0]};
                else
                        r.src = {1'b0, op_b[2:0]};
        end
        else if (op_b >= 8'hB0 && op_b <= 8'hBF)
        begin
                r.seq_addr = SEQ_MOVIR + seq_addr_t'(op_b[3]);
                r.need_imm = 1'b1;
                r.imm_size = op_b[3];
                r.dst      = {1'b0, op_b[2:0]};
        end
        r.base  = REG_NONE;
        r.index = REG_NONE;
        r.seg   = SEG_DS;
        if (r.need_modrm && !direct)
        begin
                if (rm < 3'd4)
                begin
                        r.base  = rm[1] ? REG_BP : REG_BX;
                        r.index = rm[0] ? REG_DI : REG_SI;
                end
                else
                        r.base = (rm == 3'd4) ? REG_SI : (rm == 3'd5) ? REG_DI :
                                 (rm == 3'd6) ? REG_BP : REG_BX;
                r.seg = (r.base == REG_BP) ? SEG_SS : SEG_DS;
        end
        if (r.need_modrm)
        begin
                r.need_off = direct || md == 2'd1 || md == 2'd2;
                r.off_size = direct || md == 2'd2;
        end
        return r;
endfunction

`endif

//--- test/opcode_deco_tb.sv
// Testbench of the registered opcode decoder. Directed and random
// opcode/ModR/M pairs are strobed in on the falling edge; assertions
// compare each decoded record against the reference model.

module opcode_deco_tb
        import isa_pkg::*;
        import micro_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int N_RANDOM  = 300;
        localparam int MAX_CYCLE = 1000;  // 3 reset + 600 stimulus + margin

        logic       clk;
        logic       rst_n;
        logic       op_valid;
        logic [7:0] op;
        logic [7:0] modrm;
        logic       deco_valid;
        deco_t      deco;

        deco_t      exp_q[$];
        deco_t      cur_exp = '0;
        logic       cur_have = 1'b0;
        int         errors = 0;
        int         checked = 0;
        int         sent = 0;
        int         cycles = 0;
        logic [7:0] halt_ops [8] = '{8'h06, 8'h27, 8'h0F, 8'h84, 8'hA0, 8'hC3, 8'hF4, 8'hFF};

        `include "deco_expect.svh"

        opcode_deco opcode_deco_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .op_valid   (op_valid),
                .op         (op),
                .modrm      (modrm),
                .deco_valid (deco_valid),
                .deco       (deco)
        );

        initial
        begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLE)
                begin
                        $display("timeout after %0d cycles, decoder never drained", cycles);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        // inputs are stable here, so the model sees what the DUT samples
        always @(posedge clk)
        begin
                if (rst_n && op_valid)
                        exp_q.push_back(expected_record(op, modrm));
        end

        always @(negedge clk)
        begin
                cur_have = 1'b0;
                if (deco_valid === 1'b1 && exp_q.size() > 0)
                begin
                        cur_exp  = exp_q.pop_front();
                        cur_have = 1'b1;
                        checked++;
                end
        end

        task automatic compare_field(input string name, input logic [15:0] expv,
                                     input logic [15:0] gotv);
                if (gotv !== expv)
                begin
                        errors++;
                        $display("[ERROR] %s exp %h got %h", name, expv, gotv);
                end
        endtask

        task automatic compare_record(input deco_t e, input deco_t g);
                compare_field("seq_addr", 16'(e.seq_addr), 16'(g.seq_addr));
                compare_field("need_modrm", 16'(e.need_modrm), 16'(g.need_modrm));
                compare_field("need_off", 16'(e.need_off), 16'(g.need_off));
                compare_field("off_size", 16'(e.off_size), 16'(g.off_size));
                compare_field("need_imm", 16'(e.need_imm), 16'(g.need_imm));
                compare_field("imm_size", 16'(e.imm_size), 16'(g.imm_size));
                compare_field("src", 16'(e.src), 16'(g.src));
                compare_field("dst", 16'(e.dst), 16'(g.dst));
                compare_field("base", 16'(e.base), 16'(g.base));
                compare_field("index", 16'(e.index), 16'(g.index));
                compare_field("seg", 16'(e.seg), 16'(g.seg));
        endtask

        a_latency: assert property (@(posedge clk) disable iff (!rst_n)
                deco_valid === $past(op_valid, 2))
                else
                begin
                        errors++;
                        $display("deco_valid is out of step with op_valid two edges earlier");
                end

        a_pending: assert property (@(posedge clk) disable iff (!rst_n)
                deco_valid |-> cur_have)
                else
                begin
                        errors++;
                        $display("deco_valid came with no strobe outstanding");
                end

        a_record: assert property (@(posedge clk) disable iff (!rst_n)
                (deco_valid && cur_have) |-> (deco === cur_exp))
                else compare_record(cur_exp, $sampled(deco));

        task automatic strobe_pair(input logic [7:0] op_byte, input logic [7:0] modrm_byte);
                @(negedge clk);
                op_valid = 1'b1;
                op       = op_byte;
                modrm    = modrm_byte;
                sent++;
        endtask

        task automatic idle_cycles(input int n);
                repeat (n)
                begin
                        @(negedge clk);
                        op_valid = 1'b0;
                        op       = 8'($urandom);  // ignored without strobe
                end
        endtask

        function automatic logic [7:0] random_opcode();
                logic [7:0] r;
                r = 8'($urandom);
                case ($urandom % 8)
                        0, 1: return {2'b00, r[5:3], 1'b0, r[1:0]};  // alu r/m
                        2: return {2'b00, r[5:3], 2'b10, r[0]};      // accumulator imm
                        3: return {6'b100000, r[1:0]};
                        4: return {6'b100010, r[1:0]};
                        5: return {3'b010, r[4:0]};
                        6: return {4'b1011, r[3:0]};
                        default: return r;
                endcase
        endfunction

        initial
        begin
                void'($urandom(80));
                rst_n    = 1'b0;
                op_valid = 1'b0;
                op       = 8'h00;
                modrm    = 8'h00;
                repeat (3) @(negedge clk);
                rst_n = 1'b1;
                a_reset_clear: assert (deco_valid === 1'b0 && deco === '0)
                        else
                        begin
                                errors++;
                                $display("[ERROR] after reset deco_valid %h deco %h",
                                         deco_valid, deco);
                        end
                idle_cycles(2);
                for (int i = 0; i < 32; i++)  // every mod/rm pair
                        strobe_pair(8'h02 | 8'(i & 1), {i[4:3], 3'd5, i[2:0]});
                for (int i = 0; i < 32; i++)
                        strobe_pair(8'h80 + 8'(i & 3), {1'b1, i[0], i[4:2], i[2:0]});
                for (int o = 'h88; o < 'h8C; o++)
                begin
                        strobe_pair(8'(o), 8'hC5);
                        strobe_pair(8'(o), 8'h46);
                        strobe_pair(8'(o), 8'h9A);
                end
                for (int o = 'h40; o < 'h60; o++)
                        strobe_pair(8'(o), 8'($urandom));
                for (int o = 'hB0; o < 'hC0; o++)
                        strobe_pair(8'(o), 8'($urandom));
                foreach (halt_ops[i])
                begin
                        idle_cycles(i % 2);
                        strobe_pair(halt_ops[i], 8'($urandom));
                end
                for (int n = 0; n < N_RANDOM; n++)
                begin
                        if ($urandom % 8 == 0)
                                idle_cycles(1 + $urandom % 3);
                        strobe_pair(random_opcode(), 8'($urandom));
                end
                idle_cycles(1);
                idle_cycles(2);
                a_all_out: assert (checked == sent)
                        else
                        begin
                                errors++;
                                $display("only %0d records came back for %0d strobes",
                                         checked, sent);
                        end
                $display("checked %0d records of %0d strobes, %0d errors", checked, sent, errors);
                if (errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule
